//--- hdl/smc_access_fsm.sv
/* Access sequencer for the external bank.
   Runs csle, strobe and cste for their fixed lengths, then one done
   cycle. A new access in the done cycle chains straight into csle. */
module smc_access_fsm
  import smc_emi_pkg::*;
(
  input  logic       hclk,
  input  logic       reset,
  input  logic       new_access,
  output smc_state_t state,
  output logic       smc_busy
);

  smc_state_t       state_nxt;
  logic [cnt_w-1:0] cnt;       // Cycles left in this phase
  logic [cnt_w-1:0] cnt_nxt;
  logic             last;      // Final cycle of the phase

  assign last = (cnt == '0);

  // --------------------
  // Next state
  // --------------------
  always_comb begin
    state_nxt = state;
    cnt_nxt   = last ? cnt : cnt - 1'b1;  // Count down within a phase

    case (state)
      st_idle: begin
        if (new_access) begin
          state_nxt = st_csle;
          cnt_nxt   = cnt_w'(csle_cycles - 1);
        end
      end

      st_csle: begin
        if (last) begin
          state_nxt = st_strobe;
          cnt_nxt   = cnt_w'(ws_cycles - 1);
        end
      end

      st_strobe: begin
        if (last) begin
          state_nxt = st_cste;
          cnt_nxt   = cnt_w'(cste_cycles - 1);
        end
      end

      st_cste: begin
        if (last) begin
          state_nxt = st_done;  // One cycle only
        end
      end

      st_done: begin
        // Next address overlaps this data phase
        if (new_access) begin
          state_nxt = st_csle;
          cnt_nxt   = cnt_w'(csle_cycles - 1);
        end else begin
          state_nxt = st_idle;
        end
      end

      default: begin
        state_nxt = st_idle;
        cnt_nxt   = '0;
      end
    endcase
  end

  // --------------------
  // State register
  // --------------------
  always_ff @(posedge hclk) begin
    if (reset) begin
      state <= st_idle;
      cnt   <= '0;
    end else begin
      state <= state_nxt;
      cnt   <= cnt_nxt;
    end
  end

  assign smc_busy = (state != st_idle);

endmodule

//--- hdl/smc_ahb_pkg.sv
/* AHB-lite side definitions for the static memory controller.
   Only single transfers of byte, halfword or word size are handled.
   The slave never signals an error, so only the OKAY code is defined. */
package smc_ahb_pkg;

  // Bus widths
  localparam int addr_w = 32;
  localparam int data_w = 32;

  // --------------------
  // Transfer encodings
  // --------------------
  typedef enum logic [1:0] {
    htrans_idle   = 2'b00,
    htrans_busy   = 2'b01,
    htrans_nonseq = 2'b10,
    htrans_seq    = 2'b11
  } htrans_t;

  typedef enum logic [2:0] {
    hsize_byte = 3'b000,
    hsize_half = 3'b001,
    hsize_word = 3'b010   // Widest size on a 32 bit bus
  } hsize_t;

  localparam logic [1:0] hresp_okay = 2'b00;

  // Request held for the length of one memory access
  typedef struct packed {
    logic [addr_w-1:0] addr;   // Byte address as issued
    logic              write;  // High for writes
    logic [1:0]        size;   // Low bits of hsize
  } ahb_req_t;

endpackage

//--- hdl/smc_ahb_slave.sv
/* AHB-lite slave front end. One transfer is in flight at a time and
   smc_hready stays low until the access reaches its done cycle.
   Transfers are assumed aligned to their size. */
module smc_ahb_slave
  import smc_ahb_pkg::*, smc_emi_pkg::*;
(
  input  logic              hclk,
  input  logic              reset,
  input  logic              hsel,
  input  logic              hwrite,
  input  logic              hready,
  input  logic [addr_w-1:0] haddr,
  input  htrans_t           htrans,
  input  hsize_t            hsize,
  input  logic [data_w-1:0] hwdata,
  input  smc_state_t        state,
  input  logic [data_w-1:0] rdata,
  output logic              new_access,
  output logic              smc_hready,
  output ahb_req_t          req,
  output logic [data_w-1:0] wdata,
  output logic [data_w-1:0] smc_hrdata,
  output logic [1:0]        smc_hresp,
  output logic              smc_valid
);

  logic xfer_valid;  // NONSEQ or SEQ on the bus
  logic wr_pend;     // Write data phase under way

  assign xfer_valid = (htrans == htrans_nonseq) || (htrans == htrans_seq);

  // Free when idle or in the done cycle
  assign smc_hready = (state == st_idle) || (state == st_done);

  // Address phase accepted on this edge
  assign new_access = hsel && hready && smc_hready && xfer_valid;
  assign smc_valid  = new_access;

  // --------------------
  // Address phase
  // --------------------
  always_ff @(posedge hclk) begin
    if (new_access) begin
      req.addr  <= haddr;
      req.write <= hwrite;
      req.size  <= hsize[1:0];  // Wider sizes not expected
    end
  end

  // --------------------
  // Write data phase
  // --------------------
  always_ff @(posedge hclk) begin
    if (reset) begin
      wr_pend <= 1'b0;
    end else begin
      wr_pend <= new_access && hwrite;  // Data follows one cycle later
    end
  end

  always_ff @(posedge hclk) begin
    if (wr_pend) begin
      wdata <= hwdata;  // Master holds it through the stall
    end
  end

  // --------------------
  // Response
  // --------------------
  // Read data settles before the done cycle
  assign smc_hrdata = rdata;
  assign smc_hresp  = hresp_okay;

endmodule

//--- hdl/smc_emi_driver.sv
/* Memory-side output stage. All outputs are registered and lag the
   FSM state by one cycle. The address is word aligned and lanes are
   picked by the byte enables. Read data is taken at the end of strobe. */
module smc_emi_driver
  import smc_ahb_pkg::*, smc_emi_pkg::*;
(
  input  logic              hclk,
  input  logic              reset,
  input  logic              new_access,
  input  ahb_req_t          req,
  input  logic [data_w-1:0] wdata,
  input  smc_state_t        state,
  input  logic [data_w-1:0] data_smc,
  output emi_strobe_t       emi,
  output logic [addr_w-1:0] smc_addr,
  output logic [data_w-1:0] smc_data,
  output logic [data_w-1:0] rdata
);

  logic        load_addr;   // req now holds the new access
  logic [3:0]  be;          // Active high lane decode
  logic        cs_phase;    // csle through cste
  logic        strb_phase;
  emi_strobe_t emi_nxt;

  // Little endian lanes
  always_comb begin
    case (hsize_t'({1'b0, req.size}))
      hsize_byte: be = 4'b0001 << req.addr[1:0];
      hsize_half: be = req.addr[1] ? 4'b1100 : 4'b0011;
      default:    be = 4'b1111;
    endcase
  end

  assign cs_phase   = (state == st_csle) || (state == st_strobe) || (state == st_cste);
  assign strb_phase = (state == st_strobe);

  // --------------------
  // Strobe decode
  // --------------------
  always_comb begin
    emi_nxt = emi_inactive;
    if (cs_phase) begin
      emi_nxt.n_cs     = 1'b0;
      emi_nxt.n_be     = ~be;
      emi_nxt.n_ext_oe = ~req.write;  // Drive bus only on writes
    end
    if (strb_phase) begin
      if (req.write) begin
        emi_nxt.n_wr = 1'b0;
        emi_nxt.n_we = ~be;           // Whole strobe phase
      end else begin
        emi_nxt.n_rd = 1'b0;
      end
    end
  end

  always_ff @(posedge hclk) begin
    if (reset) begin
      emi       <= emi_inactive;
      load_addr <= 1'b0;
    end else begin
      emi       <= emi_nxt;
      load_addr <= new_access;
    end
  end

  // --------------------
  // Address and data
  // --------------------
  always_ff @(posedge hclk) begin
    if (load_addr) begin
      smc_addr <= {req.addr[addr_w-1:2], 2'b00};
    end
    if (strb_phase && req.write) begin
      smc_data <= wdata;   // Valid by the time n_wr falls
    end
    // Registered n_rd still low means the last strobe cycle just ended
    if (!emi.n_rd && (state == st_cste)) begin
      rdata <= data_smc;
    end
  end

endmodule

//--- hdl/smc_emi_pkg.sv
/* External memory timing and strobe definitions.
   Each phase length must be at least 1 and its value minus one must
   fit in cnt_w bits. Every strobe in the bundle is active low. */
package smc_emi_pkg;

  // --------------------
  // Phase lengths
  // --------------------
  localparam int csle_cycles = 1;  // Chip select to strobe
  localparam int ws_cycles   = 2;  // Strobe width in wait states
  localparam int cste_cycles = 1;  // Strobe end to chip select release

  localparam int cnt_w = 2;        // Phase counter width

  // Access sequencing
  typedef enum logic [2:0] {
    st_idle   = 3'd0,
    st_csle   = 3'd1,  // Chip select leading edge
    st_strobe = 3'd2,  // Read or write strobe low
    st_cste   = 3'd3,  // Chip select trailing edge
    st_done   = 3'd4   // Data back to AHB
  } smc_state_t;

  // --------------------
  // Memory-side control bundle
  // --------------------
  typedef struct packed {
    logic       n_cs;      // Bank select
    logic       n_rd;      // Read strobe
    logic       n_wr;      // Write strobe
    logic       n_ext_oe;  // External data driver enable
    logic [3:0] n_be;      // Byte enables
    logic [3:0] n_we;      // Per-lane write strobes
  } emi_strobe_t;

  // All released
  localparam emi_strobe_t emi_inactive = '1;

endpackage

//--- hdl/smc_lite.sv
/* Static memory controller top. Bridges single AHB-lite transfers to
   one asynchronous bank with fixed timing on a 32 bit bus.
   hready is the muxed ready of the AHB system. */
module smc_lite
  import smc_ahb_pkg::*, smc_emi_pkg::*;
(
  input  logic              hclk,
  input  logic              reset,
  input  logic [addr_w-1:0] haddr,
  input  htrans_t           htrans,
  input  logic              hsel,
  input  logic              hwrite,
  input  hsize_t            hsize,
  input  logic [data_w-1:0] hwdata,
  input  logic              hready,
  input  logic [data_w-1:0] data_smc,
  output logic [data_w-1:0] smc_hrdata,
  output logic              smc_hready,
  output logic              smc_valid,
  output logic [1:0]        smc_hresp,
  output logic [addr_w-1:0] smc_addr,
  output logic [data_w-1:0] smc_data,
  output logic [3:0]        smc_n_be,
  output logic              smc_n_cs,
  output logic              smc_n_wr,
  output logic [3:0]        smc_n_we,
  output logic              smc_n_rd,
  output logic              smc_n_ext_oe,
  output logic              smc_busy
);

  logic              new_access;  // Address phase accepted
  ahb_req_t          req;
  logic [data_w-1:0] wdata;
  logic [data_w-1:0] rdata;
  smc_state_t        state;
  emi_strobe_t       emi;

  // --------------------
  // Blocks
  // --------------------
  smc_ahb_slave ahb_slave_i (
    .hclk, .reset, .hsel, .hwrite, .hready, .haddr, .htrans, .hsize,
    .hwdata, .state, .rdata, .new_access, .smc_hready, .req, .wdata,
    .smc_hrdata, .smc_hresp, .smc_valid
  );

  smc_access_fsm access_fsm_i (
    .hclk, .reset, .new_access, .state, .smc_busy
  );

  smc_emi_driver emi_driver_i (
    .hclk, .reset, .new_access, .req, .wdata, .state, .data_smc,
    .emi, .smc_addr, .smc_data, .rdata
  );

  // Bundle out to pins
  assign smc_n_cs     = emi.n_cs;
  assign smc_n_rd     = emi.n_rd;
  assign smc_n_wr     = emi.n_wr;
  assign smc_n_ext_oe = emi.n_ext_oe;
  assign smc_n_be     = emi.n_be;
  assign smc_n_we     = emi.n_we;

endmodule

//--- smc_lite.f
hdl/smc_ahb_pkg.sv
hdl/smc_emi_pkg.sv
hdl/smc_ahb_slave.sv
hdl/smc_access_fsm.sv
hdl/smc_emi_driver.sv
hdl/smc_lite.sv
testbench/smc_lite_props.sv
testbench/tb_smc_lite.sv

//--- testbench/smc_lite_props.sv
/* Protocol checks bound into smc_lite. Timing follows the phase
   lengths in smc_emi_pkg. fail_cnt counts failed checks for the bench. */
module smc_lite_props
  import smc_ahb_pkg::*, smc_emi_pkg::*;
(
  input logic              hclk,
  input logic              reset,
  input logic              smc_valid,
  input logic              hwrite,
  input logic [addr_w-1:0] haddr,
  input hsize_t            hsize,
  input logic              smc_hready,
  input logic              smc_busy,
  input logic [1:0]        smc_hresp,
  input logic              smc_n_cs,
  input logic              smc_n_rd,
  input logic              smc_n_wr,
  input logic              smc_n_ext_oe,
  input logic [3:0]        smc_n_we,
  input logic [3:0]        smc_n_be,
  input logic [data_w-1:0] hwdata,
  input logic [addr_w-1:0] smc_addr,
  input logic [data_w-1:0] smc_data,
  input smc_state_t        state
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int cs_len = csle_cycles + ws_cycles + cste_cycles;

  int unsigned       fail_cnt = 0;
  logic              wr_dphase;  // First data phase cycle of a write
  logic [data_w-1:0] exp_wdata;
  logic [addr_w-1:0] exp_addr;   // Address phase as the master drove it
  logic [1:0]        exp_size;
  logic              exp_write;

  // Lanes touched by a transfer, little endian
  function automatic logic [3:0] lane_mask(input logic [1:0] size, input logic [1:0] a);
    case (size)
      2'd0:    return 4'b0001 << a;
      2'd1:    return a[1] ? 4'b1100 : 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  always_ff @(posedge hclk) begin
    if (reset) begin
      wr_dphase <= 1'b0;
    end else begin
      wr_dphase <= smc_valid && hwrite;
    end
  end

  always_ff @(posedge hclk) begin
    if (wr_dphase) exp_wdata <= hwdata;  // Data the master put on the bus
  end

  always_ff @(posedge hclk) begin
    if (smc_valid) begin
      exp_addr  <= haddr;
      exp_size  <= hsize[1:0];
      exp_write <= hwrite;
    end
  end

  // --------------------
  // Reset and handshake
  // --------------------
  reset_idle: assert property (@(posedge hclk) $past(reset) |-> smc_hready && !smc_busy
      && smc_n_cs && smc_n_rd && smc_n_wr && smc_n_ext_oe && (&smc_n_be) && (&smc_n_we))
    else begin $error("outputs not idle in or after reset"); fail_cnt++; end

  ready_hold: assert property (@(posedge hclk) disable iff (reset)
      smc_valid |=> (!smc_hready && smc_busy) [*cs_len] ##1 (smc_hready && smc_busy))
    else begin $error("smc_hready or smc_busy wrong during an access"); fail_cnt++; end

  chain: assert property (@(posedge hclk) disable iff (reset)
      (state == st_done) && smc_valid |=> state == st_csle)
    else begin $error("back-to-back access went through idle"); fail_cnt++; end

  hresp_ok: assert property (@(posedge hclk) disable iff (reset) smc_hresp == hresp_okay)
    else begin
      $error("FAIL smc_hresp: expected %h, got %h", hresp_okay, $sampled(smc_hresp));
      fail_cnt++;
    end

  // --------------------
  // Memory strobes
  // --------------------
  cs_start: assert property (@(posedge hclk) disable iff (reset)
      $fell(smc_n_cs) |-> $past(smc_valid, 2))
    else begin $error("n_cs fell without an accepted transfer"); fail_cnt++; end

  cs_width: assert property (@(posedge hclk) disable iff (reset)
      $fell(smc_n_cs) |-> !smc_n_cs [*cs_len] ##1 smc_n_cs)
    else begin $error("n_cs width wrong"); fail_cnt++; end

  rd_strobe: assert property (@(posedge hclk) disable iff (reset)
      $fell(smc_n_cs) && !exp_write |-> ##csle_cycles (!smc_n_rd [*ws_cycles] ##1 smc_n_rd))
    else begin $error("n_rd timing wrong"); fail_cnt++; end

  wr_strobe: assert property (@(posedge hclk) disable iff (reset)
      $fell(smc_n_cs) && exp_write |-> ##csle_cycles (!smc_n_wr [*ws_cycles] ##1 smc_n_wr))
    else begin $error("n_wr timing wrong"); fail_cnt++; end

  addr_out: assert property (@(posedge hclk) disable iff (reset)
      !smc_n_cs |-> smc_addr == {exp_addr[addr_w-1:2], 2'b00})
    else begin
      $error("FAIL smc_addr: expected %h, got %h",
             {$sampled(exp_addr[addr_w-1:2]), 2'b00}, $sampled(smc_addr));
      fail_cnt++;
    end

  be_lanes: assert property (@(posedge hclk) disable iff (reset)
      !smc_n_cs |-> smc_n_be == ~lane_mask(exp_size, exp_addr[1:0]))
    else begin
      $error("FAIL smc_n_be: expected %h, got %h",
             ~lane_mask($sampled(exp_size), $sampled(exp_addr[1:0])), $sampled(smc_n_be));
      fail_cnt++;
    end

  // Bus driven for the whole chip select of a write only
  ext_oe: assert property (@(posedge hclk) disable iff (reset)
      smc_n_ext_oe == (smc_n_cs || !exp_write))
    else begin
      $error("FAIL smc_n_ext_oe: expected %h, got %h",
             $sampled(smc_n_cs || !exp_write), $sampled(smc_n_ext_oe));
      fail_cnt++;
    end

  wr_data: assert property (@(posedge hclk) disable iff (reset)
      !smc_n_wr |-> smc_data == exp_wdata)
    else begin
      $error("FAIL smc_data: expected %h, got %h", $sampled(exp_wdata), $sampled(smc_data));
      fail_cnt++;
    end

  we_lanes: assert property (@(posedge hclk) disable iff (reset)
      !smc_n_wr |-> smc_n_we == ~lane_mask(exp_size, exp_addr[1:0]))
    else begin
      $error("FAIL smc_n_we: expected %h, got %h",
             ~lane_mask($sampled(exp_size), $sampled(exp_addr[1:0])), $sampled(smc_n_we));
      fail_cnt++;
    end

  we_quiet: assert property (@(posedge hclk) disable iff (reset) smc_n_wr |-> &smc_n_we)
    else begin $error("n_we low outside a write strobe"); fail_cnt++; end

endmodule

bind smc_lite smc_lite_props props_i (.*);

//--- testbench/tb_smc_lite.sv
/* Bench for smc_lite with a 256 word memory model on address bits 9:2.
   Bus timing checks live in the bound props module. Read data is
   compared here against a shadow copy of the memory. */
module tb_smc_lite
  import smc_ahb_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int timeout_cycles = 40;
  localparam int mem_words = 256;

  logic hclk, reset, hsel, hwrite, hready;
  logic smc_hready, smc_valid, smc_busy;
  logic smc_n_cs, smc_n_wr, smc_n_rd, smc_n_ext_oe;
  logic [3:0] smc_n_be, smc_n_we;
  logic [1:0] smc_hresp;
  htrans_t htrans;
  hsize_t hsize;
  logic [31:0] haddr, hwdata, data_smc, smc_hrdata, smc_addr, smc_data;

  logic [31:0] mem [mem_words];      // Memory model
  logic [31:0] exp_mem [mem_words];  // Shadow for expected reads
  logic [31:0] lfsr = 32'h0c8f_2fad;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int mark;

  smc_lite smc_lite_i (.*);

  assign hready   = smc_hready;  // Only slave on the bus
  assign data_smc = !smc_n_rd ? mem[smc_addr[9:2]] : '0;

  // Each lane written as its n_we rises
  for (genvar l = 0; l < 4; l++) begin : g_lane
    always @(posedge smc_n_we[l]) begin
      if (!reset) mem[smc_addr[9:2]][8*l +: 8] <= smc_data[8*l +: 8];
    end
  end

  initial begin
    hclk = 1'b0;
    forever #4 hclk = ~hclk;
  end

  // Galois LFSR, one step per bit
  function logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'ha300_0000 : lfsr >> 1;
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [3:0] write_lanes(input logic [1:0] size, input logic [1:0] a);
    if (size == 2'd0) return 4'b0001 << a;
    if (size == 2'd1) return a[1] ? 4'b1100 : 4'b0011;
    return 4'b1111;
  endfunction

  task automatic end_with_failure(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $finish;
  endtask

  // Returns 1 ns into the done cycle
  task automatic wait_ready();
    int n;
    n = 0;
    do begin
      @(posedge hclk);
      #1;
      n++;
      if (n > timeout_cycles) end_with_failure("timeout waiting for smc_hready");
    end while (!smc_hready);
  endtask

  // One transfer, entered with smc_hready high
  task automatic issue(input logic wr, input logic [31:0] addr, input logic [1:0] size,
                       input logic [31:0] data);
    logic [3:0] lanes;
    logic [31:0] exp;
    hsel   = 1'b1;
    htrans = htrans_nonseq;
    haddr  = addr;
    hwrite = wr;
    hsize  = hsize_t'({1'b0, size});
    @(posedge hclk);
    #1;
    hwdata = data;  // Held until the next transfer
    hsel   = 1'b0;
    htrans = htrans_idle;
    wait_ready();
    lanes = write_lanes(size, addr[1:0]);
    exp   = exp_mem[addr[9:2]];
    if (wr) begin
      for (int l = 0; l < 4; l++) begin
        if (lanes[l]) exp_mem[addr[9:2]][8*l +: 8] = data[8*l +: 8];
      end
    end else begin
      assert (smc_hrdata === exp)
        else begin
          $display("FAIL smc_hrdata at %h: expected %h, got %h", addr, exp, smc_hrdata);
          errors++;
        end
    end
  endtask

  task automatic random_xfer(input logic wr);
    logic [1:0] size;
    logic [31:0] addr;
    size = rand_bits(2) % 3;
    addr = rand_bits(10) & ~((32'd1 << size) - 1);  // Aligned to size
    issue(wr, addr, size, rand_bits(32));
  endtask

  task automatic report(input string name, input int start);
    int now;
    now = errors + smc_lite_i.props_i.fail_cnt;
    tests_run++;
    if (now > start) begin
      tests_failed++;
      $display("test %s: %0d errors", name, now - start);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  initial begin
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
      exp_mem[i] = mem[i];
    end
    reset  = 1'b1;
    hsel   = 1'b0;
    htrans = htrans_idle;
    haddr  = '0;
    hwrite = 1'b0;
    hsize  = hsize_word;
    hwdata = '0;

    // --------------------
    // Reset
    // --------------------
    mark = 0;
    repeat (16) @(posedge hclk);
    #1 reset = 1'b0;
    repeat (3) @(posedge hclk);
    #1;
    report("reset", mark);

    // Single writes each followed by a word read
    mark = errors + smc_lite_i.props_i.fail_cnt;
    for (int i = 0; i < 10; i++) begin
      random_xfer(1'b1);
      repeat (2) @(posedge hclk);
      #1;
      issue(1'b0, {haddr[31:2], 2'b00}, 2'd2, '0);
      @(posedge hclk);
      #1;
    end
    report("single", mark);

    // --------------------
    // Back-to-back
    // --------------------
    mark = errors + smc_lite_i.props_i.fail_cnt;
    for (int i = 0; i < 24; i++) random_xfer(rand_bits(1));
    repeat (4) @(posedge hclk);
    #1;
    report("back_to_back", mark);

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed,
             errors + smc_lite_i.props_i.fail_cnt);
    if (tests_failed == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      end_with_failure("checks failed");
    end
  end

endmodule
